//--- verilog/crd_types_pkg.sv
// Credit class, counter and link-side types

package crd_types_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  localparam int NUM_CLASSES = 3;
  localparam int CRD_W       = 16;
  localparam int HDR_UPD_W   = 2;
  localparam int DATA_UPD_W  = 4;

  // Credit class carried with each segment
  typedef enum logic [1:0] {
    CLASS_P    = 2'd0,
    CLASS_NP   = 2'd1,
    CLASS_CPL  = 2'd2,
    CLASS_NONE = 2'd3
  } crd_class_e;

  // Per-counter init handshake
  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_WAIT_ACK = 2'd1,
    ST_INIT     = 2'd2,
    ST_ACTIVE   = 2'd3
  } crd_state_e;

  // --------------------------------------------------------------------------
  // Per-segment consumption, bit/field position matches crd_class_e value
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic cpl;
    logic np;
    logic p;
  } crd_dec_t;

  typedef struct packed {
    logic [1:0] cpl;
    logic [1:0] np;
    logic [1:0] p;
  } data_dec_t;

  // --------------------------------------------------------------------------
  // Link side, indexed by class
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [NUM_CLASSES-1:0]                 hdr_init;
    logic [NUM_CLASSES-1:0]                 hdr_init_ack;
    logic [NUM_CLASSES-1:0]                 data_init;
    logic [NUM_CLASSES-1:0]                 data_init_ack;
    logic [NUM_CLASSES-1:0]                 hdr_update;
    logic [NUM_CLASSES-1:0]                 data_update;
    logic [NUM_CLASSES-1:0][HDR_UPD_W-1:0]  hdr_update_cnt;
    logic [NUM_CLASSES-1:0][DATA_UPD_W-1:0] data_update_cnt;
  } crd_link_t;

  typedef struct packed {
    logic [NUM_CLASSES-1:0][CRD_W-1:0] hdr_avail;
    logic [NUM_CLASSES-1:0][CRD_W-1:0] data_avail;
  } crd_avail_t;

  typedef struct packed {
    crd_state_e [NUM_CLASSES-1:0] hdr_state;
    crd_state_e [NUM_CLASSES-1:0] data_state;
  } crd_status_t;

endpackage

//--- verilog/rx_st_pkg.sv
// Receive stream segment types

package rx_st_pkg;

  // --------------------------------------------------------------------------
  // Stream geometry
  // --------------------------------------------------------------------------
  localparam int NUM_SEGS = 4;

  // Empty dwords in an end segment, 0 to 7 of 8
  localparam int EMPTY_W = 3;

  // --------------------------------------------------------------------------
  // One segment as seen by the checker
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic                      hvalid;
    logic                      sop;
    logic                      eop;
    logic                      dvalid;
    logic [EMPTY_W-1:0]        empty;
    crd_types_pkg::crd_class_e crd_type;
    // Header attributes, presented with every segment of the packet
    logic                      has_data;
    // Start alignment, saves one dword at the end
    logic                      dw_align;
  } rx_seg_t;

  // Segment 0 in the low bits
  typedef rx_seg_t [NUM_SEGS-1:0] rx_seg_arr_t;

endpackage

//--- verilog/rx_seg_decode.sv
// Segment credit decode

`timescale 1ns/100ps

module rx_seg_decode (
  input  logic                     pld_clk,
  input  logic                     pld_rst_n,
  input  rx_st_pkg::rx_seg_t       seg_i,
  output crd_types_pkg::crd_dec_t  hdr_dec_o,
  output crd_types_pkg::data_dec_t data_dec_o
);

  import crd_types_pkg::*;

  crd_dec_t   hdr_nxt;
  data_dec_t  data_nxt;
  logic       short_end;
  logic [1:0] charge;

  // --------------------------------------------------------------------------
  // Header credit, one per start of packet
  // --------------------------------------------------------------------------
  always_comb begin
    hdr_nxt = '0;
    if (seg_i.hvalid && seg_i.sop) begin
      case (seg_i.crd_type)
        CLASS_P:   hdr_nxt.p   = 1'b1;
        CLASS_NP:  hdr_nxt.np  = 1'b1;
        CLASS_CPL: hdr_nxt.cpl = 1'b1;
        default:   hdr_nxt     = '0;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Data credit, in 4-dword units
  // --------------------------------------------------------------------------

  // Last 3 dwords empty and aligned start, so one unit less
  assign short_end = seg_i.empty[1] & seg_i.empty[0] & seg_i.dw_align;

  always_comb begin
    if (!seg_i.eop) begin
      charge = 2'd2;
    end else if (!seg_i.empty[2]) begin
      charge = short_end ? 2'd1 : 2'd2;
    end else begin
      // Upper half of the segment empty
      charge = short_end ? 2'd0 : 2'd1;
    end
  end

  always_comb begin
    data_nxt = '0;
    if (seg_i.dvalid && seg_i.has_data) begin
      case (seg_i.crd_type)
        CLASS_P:   data_nxt.p   = charge;
        CLASS_NP:  data_nxt.np  = charge;
        CLASS_CPL: data_nxt.cpl = charge;
        default:   data_nxt     = '0;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------
  always_ff @(posedge pld_clk) begin
    if (!pld_rst_n) begin
      hdr_dec_o  <= '0;
      data_dec_o <= '0;
    end else begin
      hdr_dec_o  <= hdr_nxt;
      data_dec_o <= data_nxt;
    end
  end

endmodule

//--- verilog/crd_counter.sv
// Single credit counter with init handshake

`timescale 1ns/100ps

module crd_counter (
  input  logic                                 pld_clk,
  input  logic                                 pld_rst_n,
  input  logic                                 init_i,
  input  logic                                 init_ack_i,
  input  logic                                 update_i,
  input  logic [crd_types_pkg::DATA_UPD_W-1:0] update_cnt_i,
  input  logic [rx_st_pkg::NUM_SEGS-1:0][1:0]  dec_i,
  output logic [crd_types_pkg::CRD_W-1:0]      avail_o,
  output crd_types_pkg::crd_state_e            state_o
);

  import crd_types_pkg::*;
  import rx_st_pkg::*;

  crd_state_e       state_q;
  logic [CRD_W-1:0] avail_q;
  logic [CRD_W-1:0] upd_add;
  logic [CRD_W-1:0] dec_sum;

  // --------------------------------------------------------------------------
  // Add and subtract terms
  // --------------------------------------------------------------------------
  assign upd_add = update_i ? {{(CRD_W-DATA_UPD_W){1'b0}}, update_cnt_i} : '0;

  // Total consumed over all segments this cycle, at most 8
  always_comb begin
    dec_sum = '0;
    for (int s = 0; s < NUM_SEGS; s++) begin
      dec_sum = dec_sum + {{(CRD_W-2){1'b0}}, dec_i[s]};
    end
  end

  // --------------------------------------------------------------------------
  // Init FSM and available count
  // --------------------------------------------------------------------------
  always_ff @(posedge pld_clk) begin
    if (!pld_rst_n) begin
      state_q <= ST_IDLE;
      avail_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (init_i) begin
            state_q <= ST_WAIT_ACK;
          end
        end
        ST_WAIT_ACK: begin
          if (init_i && init_ack_i) begin
            state_q <= ST_INIT;
          end
        end
        ST_INIT: begin
          // Initial credits arrive as updates while init is held
          if (init_i) begin
            avail_q <= avail_q + upd_add;
          end else begin
            state_q <= ST_ACTIVE;
          end
        end
        ST_ACTIVE: begin
          // Wraps modulo 2^16
          avail_q <= avail_q + upd_add - dec_sum;
        end
      endcase
    end
  end

  assign avail_o = avail_q;
  assign state_o = state_q;

endmodule

//--- verilog/rx_crd_check.sv
// Receive credit checker top

`timescale 1ns/100ps

module rx_crd_check (
  input  logic                      pld_clk,
  input  logic                      pld_rst_n,
  input  rx_st_pkg::rx_seg_arr_t    segs_i,
  input  crd_types_pkg::crd_link_t  link_i,
  output crd_types_pkg::crd_avail_t avail_o,
  output crd_types_pkg::crd_status_t status_o
);

  import crd_types_pkg::*;
  import rx_st_pkg::*;

  crd_dec_t  [NUM_SEGS-1:0] hdr_dec;
  data_dec_t [NUM_SEGS-1:0] data_dec;

  // Consumption regrouped per class
  logic [NUM_CLASSES-1:0][NUM_SEGS-1:0][1:0]  hdr_cls_dec;
  logic [NUM_CLASSES-1:0][NUM_SEGS-1:0][1:0]  data_cls_dec;
  logic [NUM_CLASSES-1:0][DATA_UPD_W-1:0]     hdr_upd_cnt;

  // --------------------------------------------------------------------------
  // Segment decoders
  // --------------------------------------------------------------------------
  for (genvar s = 0; s < NUM_SEGS; s++) begin : g_seg
    rx_seg_decode u_seg_dec (
      .pld_clk    (pld_clk),
      .pld_rst_n  (pld_rst_n),
      .seg_i      (segs_i[s]),
      .hdr_dec_o  (hdr_dec[s]),
      .data_dec_o (data_dec[s])
    );
  end

  // --------------------------------------------------------------------------
  // Header and data counters per class
  // --------------------------------------------------------------------------
  for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_cls
    for (genvar s = 0; s < NUM_SEGS; s++) begin : g_slice
      assign hdr_cls_dec[c][s]  = {1'b0, hdr_dec[s][c]};
      assign data_cls_dec[c][s] = data_dec[s][2*c +: 2];
    end

    assign hdr_upd_cnt[c] = {{(DATA_UPD_W-HDR_UPD_W){1'b0}}, link_i.hdr_update_cnt[c]};

    crd_counter u_hdr_crd (
      .pld_clk      (pld_clk),
      .pld_rst_n    (pld_rst_n),
      .init_i       (link_i.hdr_init[c]),
      .init_ack_i   (link_i.hdr_init_ack[c]),
      .update_i     (link_i.hdr_update[c]),
      .update_cnt_i (hdr_upd_cnt[c]),
      .dec_i        (hdr_cls_dec[c]),
      .avail_o      (avail_o.hdr_avail[c]),
      .state_o      (status_o.hdr_state[c])
    );

    crd_counter u_data_crd (
      .pld_clk      (pld_clk),
      .pld_rst_n    (pld_rst_n),
      .init_i       (link_i.data_init[c]),
      .init_ack_i   (link_i.data_init_ack[c]),
      .update_i     (link_i.data_update[c]),
      .update_cnt_i (link_i.data_update_cnt[c]),
      .dec_i        (data_cls_dec[c]),
      .avail_o      (avail_o.data_avail[c]),
      .state_o      (status_o.data_state[c])
    );
  end

endmodule

//--- verification/tb_clk_gen.sv
// Testbench clock and reset

`timescale 1ns/100ps

module tb_clk_gen (
  output logic pld_clk_o,
  output logic pld_rst_n_o
);

  localparam int HALF_PERIOD = 50;
  localparam int RST_CYCLES  = 4;
  localparam int RST_DLY     = 10;

  initial begin
    pld_clk_o = 1'b0;
    forever #(HALF_PERIOD) pld_clk_o = ~pld_clk_o;
  end

  // Released just after an edge, away from sampling
  initial begin
    pld_rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge pld_clk_o);
    #(RST_DLY) pld_rst_n_o = 1'b1;
  end

endmodule

//--- verification/rx_crd_check_assertions.sv
// Credit counter assertions

`timescale 1ns/100ps

module rx_crd_check_assertions (
  input logic                            pld_clk,
  input logic                            pld_rst_n,
  input crd_types_pkg::crd_state_e       state_i,
  input logic [crd_types_pkg::CRD_W-1:0] avail_i
);

  import crd_types_pkg::*;

  int fail_cnt = 0;

  // --------------------------------------------------------------------------
  // Init FSM
  // --------------------------------------------------------------------------
  a_active_kept: assert property (
    @(posedge pld_clk) disable iff (!pld_rst_n)
      state_i == ST_ACTIVE |=> state_i == ST_ACTIVE
  ) else begin
    fail_cnt++;
    $error("Counter left ST_ACTIVE");
  end

  // Only WAIT_ACK leads into INIT
  a_init_entry: assert property (
    @(posedge pld_clk) disable iff (!pld_rst_n)
      (state_i != ST_WAIT_ACK && state_i != ST_INIT) |=> state_i != ST_INIT
  ) else begin
    fail_cnt++;
    $error("Counter entered ST_INIT from a state other than ST_WAIT_ACK");
  end

  // --------------------------------------------------------------------------
  // Count frozen before init credits arrive
  // --------------------------------------------------------------------------
  a_avail_frozen: assert property (
    @(posedge pld_clk) disable iff (!pld_rst_n)
      (state_i == ST_IDLE || state_i == ST_WAIT_ACK) |=> $stable(avail_i)
  ) else begin
    fail_cnt++;
    $error("Counter changed its available count before ST_INIT");
  end

endmodule

bind crd_counter rx_crd_check_assertions u_assert (
  .pld_clk   (pld_clk),
  .pld_rst_n (pld_rst_n),
  .state_i   (state_o),
  .avail_i   (avail_o)
);

//--- verification/rx_crd_check_tb.sv
// Receive credit checker testbench

`timescale 1ns/100ps

module rx_crd_check_tb;

  import crd_types_pkg::*;
  import rx_st_pkg::*;

  localparam string PAT_FILE     = "verification/rx_crd_check_patterns.txt";
  localparam int    REC_W        = 11;
  localparam int    MAX_REC      = 64;
  localparam int    MAX_GAP      = 3;
  localparam int    DRIVE_DLY    = 10;
  localparam int    CLK_PERIOD   = 100;
  localparam int    RST_CYCLES   = 4;
  localparam int    SLACK_CYCLES = 20;
  localparam int    SEED         = 32'he569e1cf;

  // Word offsets inside one record, seg3 first
  localparam int F_HCTL   = 4;
  localparam int F_DCTL   = 5;
  localparam int F_HCNT   = 6;
  localparam int F_DCNT   = 7;
  localparam int F_FLAG   = 8;
  localparam int F_AVAIL  = 9;
  localparam int F_STATUS = 10;

  logic        pld_clk;
  logic        pld_rst_n;
  rx_seg_arr_t segs;
  crd_link_t   link;
  crd_avail_t  avail;
  crd_status_t status;

  logic [95:0] pat_mem [0:REC_W*MAX_REC-1];
  int          n_rec;
  int          n_gaps;
  int          n_checks;
  int          avail_errs;
  int          status_errs;
  int          other_errs;
  bit          pat_loaded;

  tb_clk_gen u_clk_gen (
    .pld_clk_o   (pld_clk),
    .pld_rst_n_o (pld_rst_n)
  );

  rx_crd_check i_dut (
    .pld_clk   (pld_clk),
    .pld_rst_n (pld_rst_n),
    .segs_i    (segs),
    .link_i    (link),
    .avail_o   (avail),
    .status_o  (status)
  );

  // --------------------------------------------------------------------------
  // Pattern decode
  // --------------------------------------------------------------------------
  task automatic load_patterns();
    int r;
    r = 0;
    n_gaps = 0;
    $readmemh(PAT_FILE, pat_mem);
    while (r < MAX_REC && pat_mem[r*REC_W + F_FLAG][3:0] !== 4'hf) begin
      if (pat_mem[r*REC_W + F_FLAG][1] === 1'b1) begin
        n_gaps++;
      end
      r++;
    end
    if (r == MAX_REC) begin
      $display("Pattern file %s has no end marker", PAT_FILE);
      other_errs++;
      n_rec = 0;
    end else begin
      n_rec = r;
    end
  endtask

  function automatic rx_seg_arr_t segs_from_rec(input int base);
    rx_seg_arr_t s;
    for (int i = 0; i < NUM_SEGS; i++) begin
      s[i] = rx_seg_t'(pat_mem[base + NUM_SEGS - 1 - i][$bits(rx_seg_t)-1:0]);
    end
    return s;
  endfunction

  // One hex digit per class, P in the lowest digit
  function automatic crd_link_t link_from_rec(input int base);
    logic [11:0] hctl;
    logic [11:0] dctl;
    logic [11:0] hcnt;
    logic [11:0] dcnt;
    crd_link_t   l;
    hctl = pat_mem[base + F_HCTL][11:0];
    dctl = pat_mem[base + F_DCTL][11:0];
    hcnt = pat_mem[base + F_HCNT][11:0];
    dcnt = pat_mem[base + F_DCNT][11:0];
    l = '0;
    for (int c = 0; c < NUM_CLASSES; c++) begin
      l.hdr_init[c]        = hctl[4*c+3];
      l.hdr_init_ack[c]    = hctl[4*c+2];
      l.hdr_update[c]      = hctl[4*c+1];
      l.data_init[c]       = dctl[4*c+3];
      l.data_init_ack[c]   = dctl[4*c+2];
      l.data_update[c]     = dctl[4*c+1];
      l.hdr_update_cnt[c]  = hcnt[4*c +: HDR_UPD_W];
      l.data_update_cnt[c] = dcnt[4*c +: DATA_UPD_W];
    end
    return l;
  endfunction

  function automatic crd_status_t status_from_rec(input int base);
    logic [23:0] st;
    crd_status_t s;
    st = pat_mem[base + F_STATUS][23:0];
    for (int c = 0; c < NUM_CLASSES; c++) begin
      s.hdr_state[c]  = crd_state_e'(st[4*(c+NUM_CLASSES) +: 2]);
      s.data_state[c] = crd_state_e'(st[4*c +: 2]);
    end
    return s;
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_avail(input crd_avail_t got, input crd_avail_t exp, input int idx);
    if (got !== exp) begin
      avail_errs++;
      $display("[ERROR] avail_o: got %h, expected %h (pattern %0d)", got, exp, idx);
    end
  endtask

  task automatic check_status(input crd_status_t got, input crd_status_t exp, input int idx);
    if (got !== exp) begin
      status_errs++;
      $display("[ERROR] status_o: got %h, expected %h (pattern %0d)", got, exp, idx);
    end
  endtask

  function int assert_failures();
    return i_dut.g_cls[0].u_hdr_crd.u_assert.fail_cnt
         + i_dut.g_cls[1].u_hdr_crd.u_assert.fail_cnt
         + i_dut.g_cls[2].u_hdr_crd.u_assert.fail_cnt
         + i_dut.g_cls[0].u_data_crd.u_assert.fail_cnt
         + i_dut.g_cls[1].u_data_crd.u_assert.fail_cnt
         + i_dut.g_cls[2].u_data_crd.u_assert.fail_cnt;
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus, entered and left just after a rising edge
  // --------------------------------------------------------------------------
  task automatic drive_idle(input int cycles);
    segs = '0;
    link = '0;
    repeat (cycles) begin
      @(posedge pld_clk);
      #(DRIVE_DLY);
    end
  endtask

  task automatic run_record(input int r);
    int         base;
    int         gap;
    logic [3:0] flag;
    base = r * REC_W;
    flag = pat_mem[base + F_FLAG][3:0];
    segs = segs_from_rec(base);
    link = link_from_rec(base);
    @(posedge pld_clk);
    #(DRIVE_DLY);
    if (flag[0]) begin
      n_checks++;
      check_avail(avail, crd_avail_t'(pat_mem[base + F_AVAIL]), r + 1);
      check_status(status, status_from_rec(base), r + 1);
    end
    if (flag[1]) begin
      gap = $urandom % (MAX_GAP + 1);
      drive_idle(gap);
    end
  endtask

  initial begin : main_seq
    int total;
    segs        = '0;
    link        = '0;
    n_rec       = 0;
    n_checks    = 0;
    avail_errs  = 0;
    status_errs = 0;
    other_errs  = 0;
    void'($urandom(SEED));
    load_patterns();
    pat_loaded = 1'b1;
    wait (pld_rst_n === 1'b1);
    @(posedge pld_clk);
    #(DRIVE_DLY);
    for (int r = 0; r < n_rec; r++) begin
      run_record(r);
    end
    if (n_checks == 0) begin
      $display("No output checks were run");
      other_errs++;
    end
    total = avail_errs + status_errs + other_errs + assert_failures();
    $display("Checks: %0d, avail errors: %0d, status errors: %0d, assertion failures: %0d, %s%0d",
             n_checks, avail_errs, status_errs, assert_failures(), "other errors: ", other_errs);
    if (total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Limit covers reset, every record and the longest idle gaps
  initial begin : watchdog
    int limit_ns;
    wait (pat_loaded);
    limit_ns = (n_rec + n_gaps*MAX_GAP + RST_CYCLES + SLACK_CYCLES) * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: pattern run did not finish within %0d ns", limit_ns);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- verification/rx_crd_check_patterns.txt
// seg3 seg2 seg1 seg0 | hdr_ctl data_ctl (init 8, ack 4, upd 2) hdr_cnt data_cnt | flag | avail status
// seg hex {hvalid,sop,eop}{dvalid,empty}{class,has_data,dw_align}; class digits CPL NP P left to right
// flag bit0 check outputs, bit1 idle gap follows, f end

// Reset, init handshake, segments before ACTIVE dropped
000 000 000 682  000 000 000 000  1 0000_0000_0000_0000_0000_0000 000000
000 000 000 682  888 888 000 000  1 0000_0000_0000_0000_0000_0000 111111
000 000 000 000  ccc ccc 000 000  1 0000_0000_0000_0000_0000_0000 222222
000 000 686 000  eee eee 123 fac  1 0001_0002_0003_000f_000a_000c 222222
000 000 000 000  eee eee 333 fff  1 0004_0005_0006_001e_0019_001b 222222
000 000 000 000  000 000 000 000  3 0004_0005_0006_001e_0019_001b 333333

// Header consumption, NONE class and no-sop segments ignored
600 604 600 60c  000 000 000 000  0 0 0
608 608 60c 408  000 000 000 000  1 0004_0004_0004_001e_0019_001b 333333
000 000 000 000  000 000 000 000  3 0002_0004_0004_001e_0019_001b 333333

// Data consumption, 2/1/0 rule per class
1f3 1a3 1b3 082  000 000 000 000  0 0 0
084 1b6 1f6 1c6  000 000 000 000  1 0002_0004_0004_001e_0019_0016 333333
08e 00a 18b 1db  000 000 000 000  1 0002_0004_0004_001e_0015_0016 333333
000 000 000 000  000 000 000 000  3 0002_0004_0004_001b_0015_0016 333333

// Update with consumption in one cycle, header count wraps
000 000 182 682  000 000 000 000  0 0 0
608 608 608 608  002 002 003 005  1 0002_0004_0006_001b_0015_0017 333333
000 000 000 000  200 000 100 000  1 ffff_0004_0006_001b_0015_0017 333333
000 000 000 000  200 000 300 000  3 0002_0004_0006_001b_0015_0017 333333

// More end segments, then full charge on all four segments
1f7 087 197 1e7  000 000 000 000  0 0 0
000 000 000 000  000 000 000 000  3 0002_0004_0006_001b_0010_0017 333333
08a 08a 08a 08a  000 000 000 000  0 0 0
000 000 000 000  000 000 000 000  3 0002_0004_0006_0013_0010_0017 333333

// End marker
000 000 000 000  000 000 000 000  f 0 0

//--- filelist.f
verilog/crd_types_pkg.sv
verilog/rx_st_pkg.sv
verilog/rx_seg_decode.sv
verilog/crd_counter.sv
verilog/rx_crd_check.sv
verification/tb_clk_gen.sv
verification/rx_crd_check_assertions.sv
verification/rx_crd_check_tb.sv
